// File: hw/sprite_consts.svh
`ifndef SPRITE_CONSTS_SVH
`define SPRITE_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// table geometry
//////////////////////////////////////////////////////////////////////
`define SPRITE_COUNT 31             // entries 1 to 31
`define SPRITE_LINE  20             // sprite height in lines
`define IDX_W        5              // entry number width

//////////////////////////////////////////////////////////////////////
// field widths and slots in the data word
//////////////////////////////////////////////////////////////////////
`define X_W          10
`define Y_W          9
`define OFF_W        9
`define DATA_W       32

`define X_LSB        18             // x sits in data[27:18]
`define Y_LSB        9              // y sits in data[17:9]
`define OFF_LSB      0              // offset sits in data[8:0]

`define MISS_CODE    32'h0000_0001  // no sprite at the queried pixel

`endif

// File: hw/sprite_pkg.sv
`include "sprite_consts.svh"

package sprite_pkg;

	//////////////////////////////////////////////////////////////////////
	// scalar types
	//////////////////////////////////////////////////////////////////////
	typedef logic [`IDX_W-1:0]  sprite_idx_t;   // 0 is not a valid entry
	typedef logic [`X_W-1:0]    sprite_x_t;
	typedef logic [`Y_W-1:0]    sprite_y_t;
	typedef logic [`OFF_W-1:0]  sprite_off_t;
	typedef logic [`DATA_W-1:0] sprite_word_t;  // data in and read word out

	// field select codes, 3 is left undefined
	typedef enum logic [1:0] {
		FIELD_OFFSET = 2'd0,
		FIELD_Y      = 2'd1,
		FIELD_X      = 2'd2
	} sprite_field_e;

	//////////////////////////////////////////////////////////////////////
	// composite types
	//////////////////////////////////////////////////////////////////////

	// same bit layout as the field slots of the data word
	typedef struct packed {
		logic [3:0]  rsvd;  // always zero
		sprite_x_t   x;
		sprite_y_t   y;
		sprite_off_t off;
	} sprite_entry_t;

	// pixel query, x above y
	typedef struct packed {
		sprite_x_t x;
		sprite_y_t y;
	} sprite_query_t;

endpackage

// File: hw/sprite_wr_if.sv
`timescale 1ns/1ps

`include "sprite_consts.svh"

// one decoded field write, already screened by the decoder
interface sprite_wr_if import sprite_pkg::*; ();

	logic            en;     // strobe, applied at the next rising edge
	sprite_idx_t     idx;    // 1 to 31
	sprite_field_e   field;
	logic [`X_W-1:0] value;  // field value, right aligned

	// decoder side
	modport decode_mp (
		output en,
		output idx,
		output field,
		output value
	);

	// table side
	modport table_mp (
		input en,
		input idx,
		input field,
		input value
	);

endinterface

// File: hw/sprite_write_decode.sv
`timescale 1ns/1ps

`include "sprite_consts.svh"

module sprite_write_decode import sprite_pkg::*; (
	input  logic               written,
	input  sprite_idx_t        n_reg,
	input  sprite_field_e      select_field,
	input  sprite_word_t       data,
	sprite_wr_if.decode_mp     wr
);

	logic            field_ok;   // select_field is one of the three codes
	logic            idx_ok;     // entry number is not zero
	logic [`X_W-1:0] field_val;

	//////////////////////////////////////////////////////////////////////
	// field extraction
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		field_ok  = 1'b1;
		field_val = '0;
		case (select_field)
			FIELD_X: begin
				field_val = data[`X_LSB +: `X_W];
			end
			FIELD_Y: begin
				field_val = {{(`X_W - `Y_W){1'b0}}, data[`Y_LSB +: `Y_W]};
			end
			FIELD_OFFSET: begin
				field_val = {{(`X_W - `OFF_W){1'b0}}, data[`OFF_LSB +: `OFF_W]};
			end
			default: begin
				field_ok = 1'b0;   // code 3 has no field
			end
		endcase
	end

	assign idx_ok = (n_reg != '0);

	//////////////////////////////////////////////////////////////////////
	// drive the write bus
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		wr.en    = written && idx_ok && field_ok;  // rejected writes stay off the bus
		wr.idx   = n_reg;
		wr.field = select_field;
		wr.value = field_val;
	end

endmodule

// File: hw/sprite_table.sv
`timescale 1ns/1ps

`include "sprite_consts.svh"

module sprite_table import sprite_pkg::*; (
	input  logic                    clk,
	input  logic                    arst_n,
	sprite_wr_if.table_mp           wr,
	output sprite_entry_t           entries [`SPRITE_COUNT],
	output logic [`SPRITE_COUNT-1:0] valid,
	output logic                    done
);

	//////////////////////////////////////////////////////////////////////
	// entry storage
	//////////////////////////////////////////////////////////////////////

	// entry number i+1 lives in slot i
	for (genvar i = 0; i < `SPRITE_COUNT; i++) begin : g_entry

		logic          sel;       // this entry is addressed
		sprite_entry_t entry_q;
		logic          valid_q;   // set on the first accepted write

		assign sel = wr.en && (wr.idx == sprite_idx_t'(i + 1));

		always_ff @(posedge clk or negedge arst_n) begin
			if (!arst_n) begin
				entry_q <= '0;
				valid_q <= 1'b0;
			end else if (sel) begin
				valid_q <= 1'b1;
				// only the addressed field changes
				case (wr.field)
					FIELD_X: begin
						entry_q.x <= wr.value;
					end
					FIELD_Y: begin
						entry_q.y <= wr.value[`Y_W-1:0];
					end
					FIELD_OFFSET: begin
						entry_q.off <= wr.value[`OFF_W-1:0];
					end
					default: begin
						entry_q <= entry_q;   // never sent by the decoder
					end
				endcase
			end
		end

		assign entries[i] = entry_q;
		assign valid[i]   = valid_q;

	end

	//////////////////////////////////////////////////////////////////////
	// write done pulse
	//////////////////////////////////////////////////////////////////////

	// high for the one cycle after an accepted write
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			done <= 1'b0;
		end else begin
			done <= wr.en;
		end
	end

endmodule

// File: hw/sprite_hit_scan.sv
`timescale 1ns/1ps

`include "sprite_consts.svh"

module sprite_hit_scan import sprite_pkg::*; (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     written,
	input  sprite_query_t            check,
	input  sprite_entry_t            entries [`SPRITE_COUNT],
	input  logic [`SPRITE_COUNT-1:0] valid,
	output sprite_word_t             read_data
);

	// distance from the top line to the last line of a sprite
	localparam logic [`Y_W:0] span = `SPRITE_LINE - 1;

	logic [`SPRITE_COUNT-1:0] hit;
	logic [`Y_W:0]            y_bot [`SPRITE_COUNT];  // one bit wider, no wrap
	sprite_word_t             next_word;

	//////////////////////////////////////////////////////////////////////
	// per entry compare
	//////////////////////////////////////////////////////////////////////
	for (genvar i = 0; i < `SPRITE_COUNT; i++) begin : g_cmp

		logic x_eq;
		logic y_in;

		assign y_bot[i] = {1'b0, entries[i].y} + span;

		assign x_eq = (check.x == entries[i].x);
		assign y_in = (check.y >= entries[i].y) &&
		              ({1'b0, check.y} <= y_bot[i]);

		assign hit[i] = valid[i] && x_eq && y_in;   // cleared entries never hit

	end

	//////////////////////////////////////////////////////////////////////
	// priority select
	//////////////////////////////////////////////////////////////////////

	// walk from the top down so the lowest numbered hit is the last one kept
	always_comb begin
		next_word = `MISS_CODE;
		for (int i = `SPRITE_COUNT - 1; i >= 0; i--) begin
			if (hit[i]) begin
				next_word = entries[i];
			end
		end
		if (written) begin
			next_word = `MISS_CODE;   // no lookup in a write cycle
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read word register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			read_data <= `MISS_CODE;
		end else begin
			read_data <= next_word;
		end
	end

endmodule

// File: hw/sprite_regfile_top.sv
`timescale 1ns/1ps

`include "sprite_consts.svh"

module sprite_regfile_top import sprite_pkg::*; (
	input  logic          clk,
	input  logic          arst_n,
	input  sprite_idx_t   n_reg,
	input  sprite_field_e select_field,
	input  logic          written,
	input  sprite_word_t  data,
	input  sprite_query_t check,
	output sprite_word_t  read_data,
	output logic          done
);

	sprite_entry_t            entries [`SPRITE_COUNT];   // table contents to the scan
	logic [`SPRITE_COUNT-1:0] valid;

	sprite_wr_if wr_bus ();

	//////////////////////////////////////////////////////////////////////
	// write path
	//////////////////////////////////////////////////////////////////////
	sprite_write_decode u_decode (
		.written      (written),
		.n_reg        (n_reg),
		.select_field (select_field),
		.data         (data),
		.wr           (wr_bus.decode_mp)
	);

	sprite_table u_table (
		.clk     (clk),
		.arst_n  (arst_n),
		.wr      (wr_bus.table_mp),
		.entries (entries),
		.valid   (valid),
		.done    (done)
	);

	//////////////////////////////////////////////////////////////////////
	// lookup path
	//////////////////////////////////////////////////////////////////////
	sprite_hit_scan u_scan (
		.clk       (clk),
		.arst_n    (arst_n),
		.written   (written),   // write cycles force a miss
		.check     (check),
		.entries   (entries),
		.valid     (valid),
		.read_data (read_data)
	);

endmodule

// File: verif/sprite_props.sv
`timescale 1ns/1ps

`include "sprite_consts.svh"

module sprite_props import sprite_pkg::*; (
	input logic         clk,
	input logic         arst_n,
	input logic         written,
	input logic         done,
	input sprite_word_t read_data
);

	int unsigned failures = 0;   // failed assertions so far

	//////////////////////////////////////////////////////////////////////
	// write done pulse
	//////////////////////////////////////////////////////////////////////
	done_single: assert property (@(posedge clk) disable iff (!arst_n)
		done |=> !done)
		else begin
			failures++;
			$error("done stayed high for two cycles");
		end

	done_after_write: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(done) |-> $past(written))
		else begin
			failures++;
			$error("done rose without a write in the cycle before");
		end

	//////////////////////////////////////////////////////////////////////
	// read word
	//////////////////////////////////////////////////////////////////////
	miss_after_write: assert property (@(posedge clk) disable iff (!arst_n)
		written |=> (read_data == `MISS_CODE))
		else begin
			failures++;
			$error("read_data is not the miss code after a write cycle");
		end

	read_known: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown(read_data))
		else begin
			failures++;
			$error("read_data has unknown bits");
		end

endmodule

bind sprite_regfile_top sprite_props u_props (
	.clk       (clk),
	.arst_n    (arst_n),
	.written   (written),
	.done      (done),
	.read_data (read_data)
);

// File: verif/tb_sprite_regfile.sv
`timescale 1ns/1ps

`include "sprite_consts.svh"

module tb_sprite_regfile import sprite_pkg::*; ();

	logic          clk;
	logic          arst_n;
	sprite_idx_t   n_reg;
	sprite_field_e select_field;
	logic          written;
	sprite_word_t  data;
	sprite_query_t check;
	sprite_word_t  read_data;
	logic          done;

	sprite_entry_t exp_entries [1:`SPRITE_COUNT];  // reference model
	logic          exp_valid   [1:`SPRITE_COUNT];
	logic [15:0]   lfsr_state = 16'd26;
	int            cycles = 0;

	sprite_regfile_top UUT (
		.clk          (clk),
		.arst_n       (arst_n),
		.n_reg        (n_reg),
		.select_field (select_field),
		.written      (written),
		.data         (data),
		.check        (check),
		.read_data    (read_data),
		.done         (done)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;   // 8 ns period
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= 2000) begin
			fail_stop("run timed out before all tests finished");
		end else if (UUT.u_props.failures != 0) begin
			fail_stop("an assertion in the bound checker failed");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// helpers and reference model
	//////////////////////////////////////////////////////////////////////
	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1);
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_step()};
		end
		return v;
	endfunction

	// returns the expected done bit
	function automatic logic model_write(input sprite_idx_t idx, input sprite_field_e fld,
			input sprite_word_t word);
		if (idx == '0) begin
			return 1'b0;
		end
		case (fld)
			FIELD_X: begin
				exp_entries[idx].x = word[`X_LSB +: `X_W];
			end
			FIELD_Y: begin
				exp_entries[idx].y = word[`Y_LSB +: `Y_W];
			end
			FIELD_OFFSET: begin
				exp_entries[idx].off = word[`OFF_LSB +: `OFF_W];
			end
			default: begin
				return 1'b0;
			end
		endcase
		exp_valid[idx] = 1'b1;
		return 1'b1;
	endfunction

	function automatic sprite_word_t model_lookup(input sprite_x_t qx, input sprite_y_t qy);
		int top;
		for (int i = 1; i <= `SPRITE_COUNT; i++) begin
			top = exp_entries[i].y;
			if (exp_valid[i] && exp_entries[i].x == qx && qy >= top &&
					qy <= top + `SPRITE_LINE - 1) begin
				return exp_entries[i];   // lowest number wins
			end
		end
		return `MISS_CODE;
	endfunction

	task automatic check_word(input string name, input sprite_word_t exp, input sprite_word_t act);
		if (act !== exp) begin
			fail_stop($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic check_done(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			fail_stop($sformatf("ERROR %s: expected done %b, actual %b", name, exp, act));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// bus tasks
	//////////////////////////////////////////////////////////////////////
	task automatic write_field(input string name, input sprite_idx_t idx,
			input sprite_field_e fld, input sprite_word_t word);
		logic exp_done;
		exp_done = model_write(idx, fld, word);
		@(posedge clk);
		written      <= 1'b1;
		n_reg        <= idx;
		select_field <= fld;
		data         <= word;
		@(posedge clk);
		written <= 1'b0;   // write lands at this edge
		@(negedge clk);
		check_done(name, exp_done, done);
		check_word(name, `MISS_CODE, read_data);   // write cycle forces a miss
	endtask

	task automatic lookup(input string name, input sprite_x_t qx, input sprite_y_t qy);
		sprite_word_t exp;
		exp = model_lookup(qx, qy);
		@(posedge clk);
		check <= {qx, qy};
		@(posedge clk);
		@(negedge clk);
		check_word(name, exp, read_data);
	endtask

	// field value in its own slot, random bits everywhere else
	function automatic sprite_word_t slot_word(input sprite_field_e fld, input int unsigned v);
		sprite_word_t w;
		w = rand_bits(32);
		case (fld)
			FIELD_X: begin
				w[`X_LSB +: `X_W] = v;
			end
			FIELD_Y: begin
				w[`Y_LSB +: `Y_W] = v;
			end
			default: begin
				w[`OFF_LSB +: `OFF_W] = v;
			end
		endcase
		return w;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////
	task automatic test_reset();
		@(negedge clk);
		check_done("reset done", 1'b0, done);
		lookup("reset origin", '0, '0);
		for (int i = 0; i < 4; i++) begin
			lookup("reset random", rand_bits(`X_W), rand_bits(`Y_W));
		end
	endtask

	task automatic test_field_writes();
		write_field("write x", 5'd5, FIELD_X, slot_word(FIELD_X, 100));
		write_field("write y", 5'd5, FIELD_Y, slot_word(FIELD_Y, 50));
		write_field("write offset", 5'd5, FIELD_OFFSET, slot_word(FIELD_OFFSET, 'h1ab));
		lookup("packed word", 10'd100, 9'd50);
		check_word("packed fields", {4'b0, 10'd100, 9'd50, 9'h1ab}, read_data);
	endtask

	task automatic test_window_edges();
		lookup("window top", 10'd100, 9'd50);
		lookup("window bottom", 10'd100, 9'd69);
		lookup("below window", 10'd100, 9'd70);
		lookup("above window", 10'd100, 9'd49);
		lookup("x minus one", 10'd99, 9'd50);
		lookup("x plus one", 10'd101, 9'd50);
	endtask

	task automatic test_priority();
		write_field("prio x3", 5'd3, FIELD_X, slot_word(FIELD_X, 200));
		write_field("prio y3", 5'd3, FIELD_Y, slot_word(FIELD_Y, 100));
		write_field("prio off3", 5'd3, FIELD_OFFSET, slot_word(FIELD_OFFSET, 'h033));
		write_field("prio x9", 5'd9, FIELD_X, slot_word(FIELD_X, 200));
		write_field("prio y9", 5'd9, FIELD_Y, slot_word(FIELD_Y, 95));
		write_field("prio off9", 5'd9, FIELD_OFFSET, slot_word(FIELD_OFFSET, 'h099));
		lookup("lower wins", 10'd200, 9'd105);
		write_field("move x3", 5'd3, FIELD_X, slot_word(FIELD_X, 300));
		lookup("other wins", 10'd200, 9'd105);
	endtask

	task automatic test_rejected_writes();
		lookup("before reject", 10'd200, 9'd105);
		write_field("entry zero", 5'd0, FIELD_X, slot_word(FIELD_X, 7));   // check still on a hit
		write_field("field three", 5'd9, sprite_field_e'(2'd3), rand_bits(32));
		lookup("after reject", 10'd200, 9'd105);
	endtask

	task automatic test_random_traffic();
		int          k;
		sprite_x_t   qx;
		sprite_y_t   qy;
		for (int n = 0; n < 40; n++) begin
			write_field("random write", sprite_idx_t'(rand_bits(3)),
				sprite_field_e'(rand_bits(2)), rand_bits(32));
			k  = 1 + rand_bits(3);   // entries 1 to 8
			qx = exp_entries[k].x + sprite_x_t'(rand_bits(2)) - 1;
			qy = exp_entries[k].y + sprite_y_t'(rand_bits(5)) - 2;
			lookup("random lookup", qx, qy);
		end
	endtask

	initial begin
		arst_n       = 1'b0;
		written      = 1'b0;
		n_reg        = '0;
		select_field = FIELD_OFFSET;
		data         = '0;
		check        = '0;
		for (int i = 1; i <= `SPRITE_COUNT; i++) begin
			exp_entries[i] = '0;
			exp_valid[i]   = 1'b0;
		end
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		test_reset();
		test_field_writes();
		test_window_edges();
		test_priority();
		test_rejected_writes();
		test_random_traffic();
		if (UUT.u_props.failures != 0) begin
			fail_stop("an assertion in the bound checker failed");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

// File: all.f
+incdir+hw
hw/sprite_pkg.sv
hw/sprite_wr_if.sv
hw/sprite_write_decode.sv
hw/sprite_table.sv
hw/sprite_hit_scan.sv
hw/sprite_regfile_top.sv
verif/sprite_props.sv
verif/tb_sprite_regfile.sv
